// ==== src/uart_master_pkg.sv ====
`default_nettype none

package uart_master_pkg;

  // clock cycles per serial bit.
  localparam int BAUD_DIV   = 16;
  // idle cycles between the two frames of a write.
  localparam int FRAME_GAP  = 16;
  localparam int CMD_W      = 16;
  localparam int BYTE_W     = CMD_W / 2;
  // start, data, parity and stop.
  localparam int FRAME_BITS = BYTE_W + 3;

  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS);
  localparam int GAP_CNT_W  = $clog2(FRAME_GAP + 1);

  typedef struct packed {
    logic              rw;
    logic [BYTE_W-2:0] addr;
    logic [BYTE_W-1:0] wdata;
  } cmd_fields_t;

  // bytes in transmit order, hi goes first.
  typedef struct packed {
    logic [BYTE_W-1:0] hi;
    logic [BYTE_W-1:0] lo;
  } cmd_frame_t;

  typedef union packed {
    cmd_fields_t fields;
    cmd_frame_t  frame;
  } uart_cmd_u;

  typedef struct packed {
    logic [BYTE_W-1:0] data;
    logic              parity_err;
    logic              stop_err;
  } rx_result_t;

endpackage

`default_nettype wire

// ==== src/uart_tx_frame.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx_frame (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               tx_start,
  input  logic [uart_master_pkg::BYTE_W-1:0] tx_byte,
  output logic                               tx,
  output logic                               tx_busy,
  output logic                               tx_done
);

  import uart_master_pkg::*;

  // data, parity and stop bits still to go after the start bit.
  logic [FRAME_BITS-2:0] shift_q;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic                  baud_tick;
  logic                  last_bit;
  logic                  load;

  assign load      = tx_start && !tx_busy;
  assign baud_tick = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
  assign last_bit  = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
  // high in the final cycle of the stop bit.
  assign tx_done   = tx_busy && baud_tick && last_bit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (load)
    begin
      tx       <= 1'b0;
      tx_busy  <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (tx_busy)
    begin
      if (baud_tick)
      begin
        baud_cnt <= '0;
        if (last_bit)
        begin
          tx      <= 1'b1;
          tx_busy <= 1'b0;
        end
        else
        begin
          tx      <= shift_q[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // even parity, LSB first.
  always_ff @(posedge clk)
  begin
    if (load)
      shift_q <= {1'b1, ^tx_byte, tx_byte};
    else if (tx_busy && baud_tick)
      shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};
  end

endmodule

`default_nettype wire

// ==== src/uart_rx_frame.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx_frame (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  output logic                        rx_done,
  output uart_master_pkg::rx_result_t rx_result
);

  import uart_master_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_CNT_W-1:0]  bit_idx;
  logic [BYTE_W-1:0]     data_q;
  logic                  parity_acc;
  logic                  half_tick;
  logic                  full_tick;

  assign half_tick = (baud_cnt == BAUD_CNT_W'(BAUD_DIV / 2 - 1));
  assign full_tick = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

  // two-flop synchronizer, plus one more stage for edge detection.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_done  <= 1'b0;
    end
    else
    begin
      rx_done  <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        RX_IDLE:
        begin
          baud_cnt <= '0;
          if (rx_prev && !rx_sync)
            state <= RX_START;
        end
        RX_START:
        begin
          // a glitch shorter than half a bit is dropped here.
          if (half_tick)
          begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA:
        begin
          if (full_tick)
          begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == BIT_CNT_W'(BYTE_W - 1))
              state <= RX_PARITY;
          end
        end
        RX_PARITY:
        begin
          if (full_tick)
          begin
            baud_cnt <= '0;
            state    <= RX_STOP;
          end
        end
        RX_STOP:
        begin
          if (full_tick)
          begin
            rx_done <= 1'b1;
            state   <= RX_IDLE;
          end
        end
        default:
        begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    case (state)
      RX_START:
        if (half_tick)
          parity_acc <= 1'b0;
      RX_DATA:
        if (full_tick)
        begin
          data_q     <= {rx_sync, data_q[BYTE_W-1:1]};
          parity_acc <= parity_acc ^ rx_sync;
        end
      RX_PARITY:
        if (full_tick)
          parity_acc <= parity_acc ^ rx_sync;
      RX_STOP:
        // even parity leaves the accumulator at zero.
        if (full_tick)
        begin
          rx_result.data       <= data_q;
          rx_result.parity_err <= parity_acc;
          rx_result.stop_err   <= !rx_sync;
        end
      default:
        ;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/uart_cmd_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_ctrl (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  uart_master_pkg::uart_cmd_u           cmd_in,
  input  logic                                 cmd_vld,
  output logic                                 cmd_rdy,
  output logic                                 tx_start,
  output logic [uart_master_pkg::BYTE_W-1:0]   tx_byte,
  input  logic                                 tx_done,
  input  logic                                 rx_done,
  input  uart_master_pkg::rx_result_t          rx_result,
  output logic                                 read_rdy,
  output logic [uart_master_pkg::BYTE_W-1:0]   read_data,
  output logic                                 read_err
);

  import uart_master_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FIRST,
    ST_GAP,
    ST_SECOND,
    ST_REPLY
  } ctrl_state_t;

  ctrl_state_t          state;
  uart_cmd_u            cmd_q;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic                 accept;
  logic                 reply_hit;

  // only idle takes a command, anything else ignores cmd_vld.
  assign cmd_rdy   = (state == ST_IDLE);
  assign accept    = cmd_rdy && cmd_vld;
  assign reply_hit = (state == ST_REPLY) && rx_done;

  // request byte first, data byte in the second frame of a write.
  assign tx_byte = (state == ST_SECOND) ? cmd_q.frame.lo : cmd_q.frame.hi;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      gap_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (accept)
          begin
            tx_start <= 1'b1;
            state    <= ST_FIRST;
          end
        end
        ST_FIRST:
        begin
          if (tx_done)
          begin
            gap_cnt <= '0;
            if (cmd_q.fields.rw)
              state <= ST_GAP;
            else
              state <= ST_REPLY;
          end
        end
        ST_GAP:
        begin
          // line stays idle high while the gap runs out.
          if (gap_cnt == GAP_CNT_W'(FRAME_GAP - 1))
          begin
            tx_start <= 1'b1;
            state    <= ST_SECOND;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        ST_SECOND:
        begin
          if (tx_done)
            state <= ST_IDLE;
        end
        ST_REPLY:
        begin
          // no timeout, wait for the slave as long as it takes.
          if (rx_done)
          begin
            read_rdy <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (reply_hit)
    begin
      read_data <= rx_result.data;
      read_err  <= rx_result.parity_err | rx_result.stop_err;
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_master (
  input  logic                               clk,
  input  logic                               rst_n,
  input  uart_master_pkg::uart_cmd_u         cmd_in,
  input  logic                               cmd_vld,
  input  logic                               rx,
  output logic                               tx,
  output logic                               cmd_rdy,
  output logic                               read_rdy,
  output logic [uart_master_pkg::BYTE_W-1:0] read_data,
  output logic                               read_err
);

  import uart_master_pkg::*;

  logic              tx_start;
  logic [BYTE_W-1:0] tx_byte;
  logic              tx_busy;
  logic              tx_done;
  logic              rx_done;
  rx_result_t        rx_result;

  uart_cmd_ctrl i_uart_cmd_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_done   (rx_done),
    .rx_result (rx_result),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame i_uart_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  uart_rx_frame i_uart_rx_frame (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_done   (rx_done),
    .rx_result (rx_result)
  );

endmodule

`default_nettype wire

// ==== dv/uart_master_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_master_properties (
  input logic clk,
  input logic rst_n,
  input logic tx_start,
  input logic tx_busy,
  input logic cmd_rdy,
  input logic read_rdy
);

  // a new frame only starts on an idle transmitter.
  start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy
  ) else $error("tx_start asserted while tx_busy is high");

  read_rdy_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy
  ) else $error("read_rdy held for more than one cycle");

  busy_blocks_host: assert property (
    @(posedge clk) disable iff (!rst_n) tx_busy |-> !cmd_rdy
  ) else $error("cmd_rdy high while tx_busy is high");

endmodule

bind uart_master uart_master_properties i_uart_master_properties (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx_start (tx_start),
  .tx_busy  (tx_busy),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy)
);

`default_nettype wire

// ==== dv/tb_uart_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_uart_master;

  import uart_master_pkg::*;

  localparam int NUM_ENTRIES = 10;
  localparam int CYCLE_LIMIT =
    NUM_ENTRIES * (3 * FRAME_BITS * BAUD_DIV + FRAME_GAP + 64) + 100;

  logic              clk;
  logic              rst_n;
  uart_cmd_u         cmd_in;
  logic              cmd_vld;
  logic              rx;
  logic              tx;
  logic              cmd_rdy;
  logic              read_rdy;
  logic [BYTE_W-1:0] read_data;
  logic              read_err;

  // cmd word, reply byte, corrupt flag, expected byte, expected error.
  logic [39:0] golden [0:NUM_ENTRIES-1];
  int          cycle_cnt = 0;

  uart_master i_uart_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("timeout: the DUT did not finish all commands within %0d cycles", CYCLE_LIMIT);
      $display("Finished with errors");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check(input logic ok, input string what);
    assert (ok)
    else
    begin
      $display("[ERROR] %0t ns: %s", $time, what);
      $display("Finished with errors");
      $fatal(1, "check failed");
    end
  endtask

  // decode one frame on tx at mid-bit and count the idle cycles before it.
  task automatic receive_frame(input logic [BYTE_W-1:0] exp_byte, output int idle_cycles);
    logic [BYTE_W-1:0] data;
    logic              par;
    int                i;
    idle_cycles = 0;
    @(negedge clk);
    while (tx)
    begin
      check(!cmd_rdy, "cmd_rdy high while a command is in progress");
      idle_cycles++;
      @(negedge clk);
    end
    repeat (BAUD_DIV / 2 - 1) @(negedge clk);
    check(!tx, "start bit on tx is not low at mid-bit");
    for (i = 0; i < BYTE_W; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      data[i] = tx;
      check(!cmd_rdy, "cmd_rdy high during a frame");
    end
    repeat (BAUD_DIV) @(negedge clk);
    par = tx;
    repeat (BAUD_DIV) @(negedge clk);
    check(tx, "stop bit on tx is low");
    check(data == exp_byte,
      $sformatf("tx frame byte 0x%02h, expected 0x%02h", data, exp_byte));
    check(par == ^exp_byte,
      $sformatf("tx parity bit %0b, expected even parity %0b", par, ^exp_byte));
  endtask

  // reply frame on rx, the stop bit is left on the line.
  task automatic send_frame(input logic [BYTE_W-1:0] data, input logic corrupt);
    logic [FRAME_BITS-1:0] bits;
    int                    i;
    bits = {1'b1, (^data) ^ corrupt, data, 1'b0};
    for (i = 0; i < FRAME_BITS - 1; i++)
    begin
      rx = bits[i];
      repeat (BAUD_DIV)
      begin
        @(negedge clk);
        check(tx && !cmd_rdy, "tx active or cmd_rdy high while the reply is sent");
      end
    end
    rx = bits[FRAME_BITS-1];
  endtask

  task automatic wait_read(input logic [BYTE_W-1:0] exp_data, input logic exp_err);
    while (!read_rdy)
    begin
      check(tx && !cmd_rdy, "tx active or cmd_rdy high while waiting for read_rdy");
      @(negedge clk);
    end
    check(cmd_rdy, "cmd_rdy not high together with read_rdy");
    check(read_data == exp_data,
      $sformatf("read_data 0x%02h, expected 0x%02h", read_data, exp_data));
    check(read_err == exp_err,
      $sformatf("read_err %0b, expected %0b", read_err, exp_err));
  endtask

  task automatic wait_write_done();
    while (!cmd_rdy)
    begin
      check(tx && !read_rdy, "tx or read_rdy active after the second stop bit");
      @(negedge clk);
    end
  endtask

  initial
  begin
    logic [CMD_W-1:0] cmd;
    int               idle;
    int               e;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    $readmemh("dv/uart_master_golden.txt", golden);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check(tx && cmd_rdy && !read_rdy, "tx, cmd_rdy or read_rdy wrong after reset");
    for (e = 0; e < NUM_ENTRIES; e++)
    begin
      check(!$isunknown(golden[e]), "golden file entry is missing or unreadable");
      cmd = golden[e][39:24];
      check(cmd_rdy, "cmd_rdy low when the next command was due");
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      @(negedge clk);
      check(!cmd_rdy && !read_rdy, "command was not accepted");
      // a held request with another word must be ignored while busy.
      cmd_in = ~cmd;
      receive_frame(cmd[CMD_W-1:BYTE_W], idle);
      if (cmd[CMD_W-1])
      begin
        receive_frame(cmd[BYTE_W-1:0], idle);
        check(idle >= BAUD_DIV / 2 + FRAME_GAP,
          $sformatf("gap of %0d idle cycles between write frames", idle - BAUD_DIV / 2));
        wait_write_done();
      end
      else
      begin
        send_frame(golden[e][23:16], golden[e][12]);
        wait_read(golden[e][11:4], golden[e][0]);
      end
    end
    cmd_vld = 1'b0;
    repeat (2 * FRAME_BITS * BAUD_DIV)
    begin
      @(negedge clk);
      check(tx && cmd_rdy && !read_rdy, "DUT active with no command pending");
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/uart_master_golden.txt ====
// columns: cmd word _ reply byte _ corrupt flag _ expected read byte _ expected error
// write when bit 15 of the cmd word is set, reply columns are unused then
8a5c_00_0_00_0
1200_a5_0_a5_0
9fff_00_0_00_0
3c00_5a_1_5a_1
0000_00_0_00_0
ff01_00_0_00_0
7f00_ff_0_ff_0
c381_00_0_00_0
2b44_81_1_81_1
6500_3e_0_3e_0

// ==== verilog.f ====
src/uart_master_pkg.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/uart_cmd_ctrl.sv
src/uart_master.sv
dv/uart_master_properties.sv
dv/tb_uart_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_uart_master -o sim_uart_master \
  && ./obj_dir/sim_uart_master \
  || { echo "simulation failed"; exit 1; }
